// ==== alu_pkg.sv ====
// ALU package with widths, word types, opcode and class enums, request struct
package alu_pkg;

  //--------------------------------------------------------------------
  // Widths
  //--------------------------------------------------------------------
  localparam int XLEN    = 32;
  localparam int SHAMT_W = $clog2(XLEN);  // 5 for RV32

  typedef logic [XLEN-1:0]    data_t;     // One operand or result word
  typedef logic [SHAMT_W-1:0] shamt_t;    // Shift amount, low bits of op2

  //--------------------------------------------------------------------
  // Opcodes, same encoding as the core's aluop field
  //--------------------------------------------------------------------
  typedef enum logic [3:0] {
    ADD_OP  = 4'd0,
    SLL_OP  = 4'd1,
    XOR_OP  = 4'd4,
    SRL_OP  = 4'd5,
    OR_OP   = 4'd6,
    AND_OP  = 4'd7,
    SUB_OP  = 4'd8,
    SRA_OP  = 4'd13,
    PASS_OP = 4'd15   // Passes op2, used for LUI
  } alu_op_e;         // Codes not listed here are illegal

  // Unit that owns the result
  typedef enum logic [1:0] {
    CLASS_NONE  = 2'd0,  // Illegal op, result forced to zero
    CLASS_ARITH = 2'd1,
    CLASS_SHIFT = 2'd2
  } res_class_e;

  // Function select inside the arith/logic unit
  typedef enum logic [2:0] {
    FN_ADD  = 3'd0,
    FN_SUB  = 3'd1,
    FN_XOR  = 3'd2,
    FN_OR   = 3'd3,
    FN_AND  = 3'd4,
    FN_PASS = 3'd5
  } logic_fn_e;

  // Shifter controls
  typedef struct packed {
    logic shift_left;  // SLL
    logic arith;       // Sign fill, SRA only
  } shift_ctl_t;

  // Decoded request, output of the issue stage
  typedef struct packed {
    data_t      op1;
    data_t      op2;
    shamt_t     shamt;
    res_class_e res_class;
    logic_fn_e  logic_fn;
    shift_ctl_t shift_ctl;
  } alu_req_t;

endpackage

// ==== alu_issue_stage.sv ====
// ALU issue stage with opcode decode and the operand/request register
`timescale 1ns/1ns

module alu_issue_stage (
  input  logic             clk,
  input  logic             i_arst_n,
  input  alu_pkg::data_t   i_op1,
  input  alu_pkg::data_t   i_op2,
  input  logic [3:0]       i_aluop,
  output alu_pkg::alu_req_t o_req
);

  alu_pkg::alu_op_e   op;         // Raw opcode seen as enum
  alu_pkg::alu_op_e   aluop_q;    // Registered opcode, assertion only
  alu_pkg::res_class_e dec_class;
  alu_pkg::logic_fn_e  dec_fn;
  alu_pkg::shift_ctl_t dec_shift;

  assign op = alu_pkg::alu_op_e'(i_aluop);

  //--------------------------------------------------------------------
  // Opcode decode
  //--------------------------------------------------------------------
  always_comb begin
    dec_class = alu_pkg::CLASS_ARITH;  // Most ops go to the arith unit
    dec_fn    = alu_pkg::FN_ADD;
    dec_shift = '0;
    case (op)
      alu_pkg::ADD_OP:  dec_fn = alu_pkg::FN_ADD;
      alu_pkg::SUB_OP:  dec_fn = alu_pkg::FN_SUB;
      alu_pkg::XOR_OP:  dec_fn = alu_pkg::FN_XOR;
      alu_pkg::OR_OP:   dec_fn = alu_pkg::FN_OR;
      alu_pkg::AND_OP:  dec_fn = alu_pkg::FN_AND;
      alu_pkg::PASS_OP: dec_fn = alu_pkg::FN_PASS;
      alu_pkg::SLL_OP: begin
        dec_class            = alu_pkg::CLASS_SHIFT;
        dec_shift.shift_left = 1'b1;
      end
      alu_pkg::SRL_OP:  dec_class = alu_pkg::CLASS_SHIFT;  // Zero fill
      alu_pkg::SRA_OP: begin
        dec_class       = alu_pkg::CLASS_SHIFT;
        dec_shift.arith = 1'b1;  // Sign fill
      end
      default:          dec_class = alu_pkg::CLASS_NONE;   // Illegal code
    endcase
  end

  //--------------------------------------------------------------------
  // Request register, first pipe stage
  //--------------------------------------------------------------------
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_req   <= '0;                // Class comes out as NONE
      aluop_q <= alu_pkg::ADD_OP;
    end else begin
      o_req.op1       <= i_op1;
      o_req.op2       <= i_op2;
      o_req.shamt     <= i_op2[alu_pkg::SHAMT_W-1:0];  // Upper bits ignored
      o_req.res_class <= dec_class;
      o_req.logic_fn  <= dec_fn;
      o_req.shift_ctl <= dec_shift;
      aluop_q         <= op;
    end
  end

  // An illegal opcode must never reach a unit with a live class
  a_illegal_is_none: assert property (@(posedge clk) disable iff (!i_arst_n)
    !(aluop_q inside {alu_pkg::ADD_OP, alu_pkg::SLL_OP, alu_pkg::XOR_OP,
                      alu_pkg::SRL_OP, alu_pkg::OR_OP, alu_pkg::AND_OP,
                      alu_pkg::SUB_OP, alu_pkg::SRA_OP, alu_pkg::PASS_OP})
    |-> o_req.res_class == alu_pkg::CLASS_NONE);

endmodule

// ==== alu_shift_unit.sv ====
// Barrel shifter for SLL, SRL and SRA, unified or separate left/right style
`timescale 1ns/1ns

module alu_shift_unit #(
  parameter bit UNIFIED_SHIFTER = 1'b1  // 1: one right shifter, 0: two shifters
) (
  input  alu_pkg::alu_req_t i_req,
  output alu_pkg::data_t    o_shift_result
);

  localparam int XLEN = alu_pkg::XLEN;

  if (UNIFIED_SHIFTER) begin : g_unified
    //------------------------------------------------------------------
    // Unified shifter
    // Left shift = reverse, shift right, reverse back
    //------------------------------------------------------------------
    alu_pkg::data_t        src;       // Operand after optional reversal
    logic                  fill;      // Bit shifted in from the top
    logic signed [XLEN:0]  shifted;   // One extra bit carries the fill
    alu_pkg::data_t        trim;

    function automatic alu_pkg::data_t reverse_bits(input alu_pkg::data_t d);
      alu_pkg::data_t r;
      for (int i = 0; i < XLEN; i++) begin
        r[i] = d[XLEN-1-i];
      end
      return r;
    endfunction

    assign src     = i_req.shift_ctl.shift_left ? reverse_bits(i_req.op1) : i_req.op1;
    assign fill    = i_req.shift_ctl.arith & src[XLEN-1];  // Zero for SLL/SRL
    assign shifted = $signed({fill, src}) >>> i_req.shamt;
    assign trim    = shifted[XLEN-1:0];

    assign o_shift_result = i_req.shift_ctl.shift_left ? reverse_bits(trim) : trim;

  end else begin : g_separate
    //------------------------------------------------------------------
    // Separate left and right shifters
    //------------------------------------------------------------------
    alu_pkg::data_t        left_res;
    logic                  fill;
    logic signed [XLEN:0]  right_ext;  // Sign-fill through the extra bit
    alu_pkg::data_t        right_res;

    assign left_res  = i_req.op1 << i_req.shamt;                // Zero fill
    assign fill      = i_req.shift_ctl.arith & i_req.op1[XLEN-1];
    assign right_ext = $signed({fill, i_req.op1}) >>> i_req.shamt;
    assign right_res = right_ext[XLEN-1:0];

    assign o_shift_result = i_req.shift_ctl.shift_left ? left_res : right_res;
  end

endmodule

// ==== alu_arith_logic_unit.sv ====
// Arith/logic unit with shared add/sub adder, bitwise ops and op2 pass
`timescale 1ns/1ns

module alu_arith_logic_unit (
  input  alu_pkg::alu_req_t i_req,
  output alu_pkg::data_t    o_arith_result
);

  logic           is_sub;    // Subtract through ~op2 + 1
  alu_pkg::data_t op2_eff;   // Adder B input
  alu_pkg::data_t sum;       // Shared adder output, carry dropped
  alu_pkg::data_t xor_res;
  alu_pkg::data_t or_res;
  alu_pkg::data_t and_res;

  //--------------------------------------------------------------------
  // Adder, one for both ADD and SUB
  //--------------------------------------------------------------------
  assign is_sub  = (i_req.logic_fn == alu_pkg::FN_SUB);
  assign op2_eff = is_sub ? ~i_req.op2 : i_req.op2;
  assign sum     = i_req.op1 + op2_eff + alu_pkg::data_t'(is_sub);  // Carry-in

  //--------------------------------------------------------------------
  // Bitwise logic
  //--------------------------------------------------------------------
  assign xor_res = i_req.op1 ^ i_req.op2;
  assign or_res  = i_req.op1 | i_req.op2;
  assign and_res = i_req.op1 & i_req.op2;

  // Output select
  always_comb begin
    case (i_req.logic_fn)
      alu_pkg::FN_ADD,
      alu_pkg::FN_SUB:  o_arith_result = sum;
      alu_pkg::FN_XOR:  o_arith_result = xor_res;
      alu_pkg::FN_OR:   o_arith_result = or_res;
      alu_pkg::FN_AND:  o_arith_result = and_res;
      alu_pkg::FN_PASS: o_arith_result = i_req.op2;  // LUI style pass
      default:          o_arith_result = '0;         // Unused fn codes
    endcase
  end

endmodule

// ==== alu_result_stage.sv ====
// ALU result stage with class-based unit select and output register
`timescale 1ns/1ns

module alu_result_stage (
  input  logic                clk,
  input  logic                i_arst_n,
  input  alu_pkg::res_class_e i_class,
  input  alu_pkg::data_t      i_shift_result,
  input  alu_pkg::data_t      i_arith_result,
  output alu_pkg::data_t      o_result
);

  //--------------------------------------------------------------------
  // Output register, second pipe stage
  //--------------------------------------------------------------------
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_result <= '0;
    end else begin
      case (i_class)
        alu_pkg::CLASS_ARITH: o_result <= i_arith_result;
        alu_pkg::CLASS_SHIFT: o_result <= i_shift_result;
        default:              o_result <= '0;  // NONE and spare code
      endcase
    end
  end

  // Illegal ops come out as zero one edge later
  a_none_gives_zero: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_class == alu_pkg::CLASS_NONE |=> o_result == '0);

endmodule

// ==== alu_pipe.sv ====
// Pipelined integer ALU top level, issue stage, shift and arith units, result stage
`timescale 1ns/1ns

module alu_pipe #(
  parameter bit UNIFIED_SHIFTER = 1'b1  // Shifter style, passed to u_shift
) (
  input  logic           clk,
  input  logic           i_arst_n,
  input  alu_pkg::data_t i_op1,
  input  alu_pkg::data_t i_op2,
  input  logic [3:0]     i_aluop,
  output alu_pkg::data_t o_result
);

  alu_pkg::alu_req_t req;           // Registered request, stage 1
  alu_pkg::data_t    shift_result;
  alu_pkg::data_t    arith_result;

  //--------------------------------------------------------------------
  // Stage 1, decode and register
  //--------------------------------------------------------------------
  alu_issue_stage u_issue (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_op1    (i_op1),
    .i_op2    (i_op2),
    .i_aluop  (i_aluop),
    .o_req    (req)
  );

  // Both units compute in parallel on the same request
  alu_shift_unit #(
    .UNIFIED_SHIFTER (UNIFIED_SHIFTER)
  ) u_shift (
    .i_req          (req),
    .o_shift_result (shift_result)
  );

  alu_arith_logic_unit u_arith (
    .i_req          (req),
    .o_arith_result (arith_result)
  );

  //--------------------------------------------------------------------
  // Stage 2, select by class and register
  //--------------------------------------------------------------------
  alu_result_stage u_result (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_class        (req.res_class),
    .i_shift_result (shift_result),
    .i_arith_result (arith_result),
    .o_result       (o_result)
  );

endmodule

// ==== tb_alu_pipe.sv ====
// Testbench for alu_pipe with operation table, random stream, reference model and watchdog
`timescale 1ns/1ns

module tb_alu_pipe #(
  parameter bit UNIFIED_SHIFTER = 1'b1  // Shifter style under test
);

  localparam int          CLK_PERIOD = 100;
  localparam int          DRIVE_DLY  = 10;   // Input skew after the rising edge
  localparam int          RESET_CYC  = 4;
  localparam int          N_RAND     = 200;
  localparam logic [31:0] SEED       = 32'hb400_ce3f;

  logic           clk;
  logic           i_arst_n;
  alu_pkg::data_t i_op1;
  alu_pkg::data_t i_op2;
  logic [3:0]     i_aluop;
  alu_pkg::data_t o_result;

  // Operation stream, table entries first, then random ops
  string          vec_name[$];
  logic [3:0]     vec_op[$];
  alu_pkg::data_t vec_op1[$];
  alu_pkg::data_t vec_op2[$];
  alu_pkg::data_t vec_exp[$];

  int pass_count;
  int fail_count;
  int table_len;    // Entries from the fixed table

  alu_pipe #(
    .UNIFIED_SHIFTER (UNIFIED_SHIFTER)
  ) i_dut (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_op1    (i_op1),
    .i_op2    (i_op2),
    .i_aluop  (i_aluop),
    .o_result (o_result)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //--------------------------------------------------------------------
  // Helpers
  //--------------------------------------------------------------------
  task automatic add_vec(input string name, input logic [3:0] op, input alu_pkg::data_t a,
                         input alu_pkg::data_t b, input alu_pkg::data_t exp);
    vec_name.push_back(name);
    vec_op.push_back(op);
    vec_op1.push_back(a);
    vec_op2.push_back(b);
    vec_exp.push_back(exp);
  endtask

  // Reference model of the ALU rules
  function automatic alu_pkg::data_t expected_result(input logic [3:0] op,
                                                     input alu_pkg::data_t a,
                                                     input alu_pkg::data_t b);
    alu_pkg::shamt_t sh;
    sh = b[alu_pkg::SHAMT_W-1:0];  // Low 5 bits only
    case (op)
      alu_pkg::ADD_OP:  return a + b;
      alu_pkg::SUB_OP:  return a - b;
      alu_pkg::XOR_OP:  return a ^ b;
      alu_pkg::OR_OP:   return a | b;
      alu_pkg::AND_OP:  return a & b;
      alu_pkg::PASS_OP: return b;
      alu_pkg::SLL_OP:  return a << sh;
      alu_pkg::SRL_OP:  return a >> sh;
      alu_pkg::SRA_OP:  return $signed(a) >>> sh;  // Sign fill
      default:          return '0;                 // Illegal code
    endcase
  endfunction

  task automatic check_data(input string name, input alu_pkg::data_t exp,
                            input alu_pkg::data_t act);
    if (act === exp) begin
      pass_count++;
      $display("PASS %s", name);
    end else begin
      fail_count++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic apply_inputs(input logic [3:0] op, input alu_pkg::data_t a,
                              input alu_pkg::data_t b);
    i_aluop = op;
    i_op1   = a;
    i_op2   = b;
  endtask

  task automatic run_watchdog(input longint limit_ns);
    #(limit_ns);
    $display("ERROR: simulation timed out after %0d ns, results stopped arriving", limit_ns);
    $display("=== FAIL ===");
    $finish;
  endtask

  //--------------------------------------------------------------------
  // Stimulus table, expected values worked out by hand
  //--------------------------------------------------------------------
  task automatic load_table();
    add_vec("add_basic",   alu_pkg::ADD_OP,  32'h0000_0005, 32'h0000_0007, 32'h0000_000c);
    add_vec("add_wrap",    alu_pkg::ADD_OP,  32'hffff_ffff, 32'h0000_0002, 32'h0000_0001);
    add_vec("sub_neg",     alu_pkg::SUB_OP,  32'h0000_0003, 32'h0000_0005, 32'hffff_fffe);
    add_vec("sub_borrow",  alu_pkg::SUB_OP,  32'h1000_0000, 32'h0000_0001, 32'h0fff_ffff);
    add_vec("xor",         alu_pkg::XOR_OP,  32'hf0f0_1234, 32'h0ff0_ffff, 32'hff00_edcb);
    add_vec("or",          alu_pkg::OR_OP,   32'ha0a0_0001, 32'h0505_8000, 32'ha5a5_8001);
    add_vec("and",         alu_pkg::AND_OP,  32'hdead_beef, 32'h0000_ffff, 32'h0000_beef);
    add_vec("pass",        alu_pkg::PASS_OP, 32'h1234_5678, 32'habcd_e000, 32'habcd_e000);
    add_vec("sll_0",       alu_pkg::SLL_OP,  32'h8000_0001, 32'h0000_0000, 32'h8000_0001);
    add_vec("sll_1",       alu_pkg::SLL_OP,  32'h8000_0001, 32'h0000_0001, 32'h0000_0002);
    add_vec("sll_31",      alu_pkg::SLL_OP,  32'h0000_0003, 32'h0000_001f, 32'h8000_0000);
    add_vec("sll_hi_bits", alu_pkg::SLL_OP,  32'h0000_0001, 32'hffff_ffe4, 32'h0000_0010);
    add_vec("srl_0",       alu_pkg::SRL_OP,  32'h8000_0000, 32'h0000_0000, 32'h8000_0000);
    add_vec("srl_1",       alu_pkg::SRL_OP,  32'h8000_0000, 32'h0000_0001, 32'h4000_0000);
    add_vec("srl_31",      alu_pkg::SRL_OP,  32'h8000_0000, 32'h0000_001f, 32'h0000_0001);
    add_vec("sra_0",       alu_pkg::SRA_OP,  32'h8000_0000, 32'h0000_0000, 32'h8000_0000);
    add_vec("sra_1",       alu_pkg::SRA_OP,  32'h8000_0000, 32'h0000_0001, 32'hc000_0000);
    add_vec("sra_31",      alu_pkg::SRA_OP,  32'h8000_0000, 32'h0000_001f, 32'hffff_ffff);
    add_vec("sra_pos",     alu_pkg::SRA_OP,  32'h7000_0000, 32'h0000_0004, 32'h0700_0000);
    add_vec("sra_hi_bits", alu_pkg::SRA_OP,  32'hf000_0000, 32'h0000_0124, 32'hff00_0000);
    add_vec("illegal_2",   4'd2,             32'h1234_5678, 32'h0000_0001, 32'h0000_0000);
    add_vec("illegal_3",   4'd3,             32'hffff_ffff, 32'hffff_ffff, 32'h0000_0000);
    add_vec("illegal_9",   4'd9,             32'h8000_0000, 32'h0000_0004, 32'h0000_0000);
    add_vec("illegal_12",  4'd12,            32'h0000_0007, 32'h0000_0003, 32'h0000_0000);
  endtask

  // Legal and illegal codes mixed, full-width operands
  task automatic add_random();
    logic [3:0]     op;
    alu_pkg::data_t a;
    alu_pkg::data_t b;
    for (int i = 0; i < N_RAND; i++) begin
      op = 4'($urandom_range(0, 15));
      a  = $urandom();
      b  = $urandom();
      add_vec($sformatf("rand_%0d_op%0d", i, op), op, a, b, expected_result(op, a, b));
    end
  endtask

  //--------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------
  initial begin
    int n;
    pass_count = 0;
    fail_count = 0;
    i_arst_n   = 1'b0;
    apply_inputs(alu_pkg::ADD_OP, '0, '0);
    void'($urandom(SEED));
    load_table();
    table_len = vec_name.size();
    add_random();
    n = vec_name.size();
    fork
      run_watchdog((longint'(table_len) + N_RAND + 10) * CLK_PERIOD * 2);
    join_none
    $display("alu_pipe run, UNIFIED_SHIFTER=%0d", UNIFIED_SHIFTER);

    repeat (RESET_CYC) begin  // Output held at zero in reset
      @(posedge clk);
      #DRIVE_DLY;
      check_data("reset_hold", '0, o_result);
    end
    i_arst_n = 1'b1;

    // One op per cycle, result due two edges after its sampling edge
    for (int i = 0; i < n + 2; i++) begin
      if (i == 1) begin
        check_data("reset_release", '0, o_result);  // Request reg still NONE
      end else if (i >= 2) begin
        check_data(vec_name[i-2], vec_exp[i-2], o_result);
      end
      if (i < n) begin
        apply_inputs(vec_op[i], vec_op1[i], vec_op2[i]);
      end else begin
        apply_inputs(alu_pkg::ADD_OP, '0, '0);      // Idle
      end
      @(posedge clk);
      #DRIVE_DLY;
    end

    $display("Tests run %0d, passed %0d, failed %0d", pass_count + fail_count,
             pass_count, fail_count);
    if (fail_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== alu_pipe.f ====
alu_pkg.sv
alu_issue_stage.sv
alu_shift_unit.sv
alu_arith_logic_unit.sv
alu_result_stage.sv
alu_pipe.sv
tb_alu_pipe.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of tb_alu_pipe for both shifter styles
set -e
cd "$(dirname "$0")"

for style in 1 0; do
  obj="obj_dir_shift${style}"
  log="sim_shift${style}.log"
  verilator --binary --timing --assert -f alu_pipe.f --top-module tb_alu_pipe \
    -GUNIFIED_SHIFTER=${style} --Mdir "${obj}" -o sim
  "./${obj}/sim" > "${log}" 2>&1
  tail -n 2 "${log}"
done

status=0
for style in 1 0; do
  if grep -q "=== FAIL ===" "sim_shift${style}.log"; then
    echo "Shifter style ${style}: failures, see sim_shift${style}.log"
    status=1
  fi
done
exit ${status}
